// File: testbench/icache_tag_input.txt
# op index tag way exp_hit exp_hit_way exp_victim name (numbers in hex)
# op: L lookup, R refill, A invalidate-all, I index-invalidate
L 3 0001234 0 0 0 0 miss_after_reset
R 0 0000000 0 0 0 0 refill_set3_way0
L 3 0001234 0 1 0 1 hit_way0
L 3 0005678 0 0 0 1 miss_second_tag
R 0 0000000 0 0 0 0 refill_set3_way1
L 3 0005678 0 2 1 0 hit_way1
L 3 0001234 0 1 0 0 alt_hit_way0
L 3 0005678 0 2 1 1 alt_hit_way1
L 3 0001234 0 1 0 0 alt_again_way0
L 9 1abcdef 0 0 0 0 miss_set9
R 0 0000000 0 0 0 0 refill_set9_way0
L 9 1abcdef 0 1 0 1 hit_set9
L a 1abcdef 0 0 0 0 other_set_miss
L 5 0001234 0 0 0 0 other_set_miss_b
I 3 0000000 0 0 0 0 inv_set3_way0
L 3 0001234 0 0 0 1 inv_way0_miss
L 3 0005678 0 2 1 1 inv_way1_still_hit
L 9 1abcdef 0 1 0 1 set9_still_hit
A 0 0000000 0 0 0 0 inv_all
L 3 0005678 0 0 0 0 inv_all_miss_set3
L 9 1abcdef 0 0 0 1 inv_all_miss_set9

// File: sources.f
src/icache_geom_pkg.sv
src/icache_cmd_pkg.sv
src/tagv_wr_if.sv
src/lutram.sv
src/icache_tagv.sv
src/icache_lru.sv
src/icache_tag_ctrl.sv
src/icache_tag.sv
testbench/icache_tag_asserts.sv
testbench/tb_icache_tag.sv

// File: Makefile
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and the log"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_icache_tag \
		-f sources.f -Mdir obj_dir
	./obj_dir/Vtb_icache_tag | tee sim.log
	grep -q "^NO ERRORS$$" sim.log

clean:
	rm -rf obj_dir sim.log

// File: testbench/tb_icache_tag.sv
`timescale 1ns/100ps

module tb_icache_tag;

    localparam int    clk_period     = 10;
    localparam int    timeout_margin = 40;
    localparam string input_file     = "testbench/icache_tag_input.txt";

    logic                      clk;
    logic                      reset;
    logic                      lookup_valid;
    icache_geom_pkg::index_t   lookup_index;
    icache_geom_pkg::tag_t     lookup_tag;
    logic                      refill_valid;
    logic                      maint_valid;
    icache_cmd_pkg::maint_op_e maint_op;
    icache_geom_pkg::index_t   maint_index;
    logic                      maint_way;
    logic                      result_valid;
    icache_geom_pkg::way_vec_t hit;
    logic                      hit_way;
    logic                      victim_way;

    // One entry per operation line
    byte                       op_q[$];
    icache_geom_pkg::index_t   index_q[$];
    icache_geom_pkg::tag_t     tag_q[$];
    logic                      way_q[$];
    icache_geom_pkg::way_vec_t exp_hit_q[$];
    logic                      exp_hit_way_q[$];
    logic                      exp_victim_q[$];
    string                     name_q[$];

    int errors;
    int checks;
    int limit;
    int cycles;

    icache_tag icache_tag_inst (
        .clk          (clk),
        .reset        (reset),
        .lookup_valid (lookup_valid),
        .lookup_index (lookup_index),
        .lookup_tag   (lookup_tag),
        .refill_valid (refill_valid),
        .maint_valid  (maint_valid),
        .maint_op     (maint_op),
        .maint_index  (maint_index),
        .maint_way    (maint_way),
        .result_valid (result_valid),
        .hit          (hit),
        .hit_way      (hit_way),
        .victim_way   (victim_way)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // Watchdog, limit is known once the input file is read
    initial begin
        cycles = 0;
        while (limit == 0 || cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout after %0d cycles, the run did not finish", cycles);
        $display("ERRORS FOUND");
        $finish;
    end

    task automatic read_input_file();
        int          fd;
        int          count;
        string       line;
        string       op;
        string       name;
        logic [31:0] idx;
        logic [31:0] tag;
        logic [31:0] way;
        logic [31:0] eh;
        logic [31:0] ehw;
        logic [31:0] ev;
        fd = $fopen(input_file, "r");
        if (fd == 0) begin
            $display("Cannot open input file %s", input_file);
            errors++;
        end else begin
            while ($fgets(line, fd) > 0) begin
                // Skip comments and blank lines
                if (line.len() > 1 && line.getc(0) != "#") begin
                    count = $sscanf(line, "%s %h %h %h %h %h %h %s",
                                    op, idx, tag, way, eh, ehw, ev, name);
                    if (count != 8) begin
                        $display("Malformed input line: %s", line);
                        errors++;
                    end else begin
                        op_q.push_back(op.getc(0));
                        index_q.push_back(icache_geom_pkg::index_t'(idx));
                        tag_q.push_back(icache_geom_pkg::tag_t'(tag));
                        way_q.push_back(way[0]);
                        exp_hit_q.push_back(icache_geom_pkg::way_vec_t'(eh));
                        exp_hit_way_q.push_back(ehw[0]);
                        exp_victim_q.push_back(ev[0]);
                        name_q.push_back(name);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic check_result(input int n);
        checks += 3;
        if (hit !== exp_hit_q[n]) begin
            errors++;
            $display("FAIL %s hit: expected %b, actual %b", name_q[n], exp_hit_q[n], hit);
        end
        if (hit_way !== exp_hit_way_q[n]) begin
            errors++;
            $display("FAIL %s hit_way: expected %0d, actual %0d",
                     name_q[n], exp_hit_way_q[n], hit_way);
        end
        if (victim_way !== exp_victim_q[n]) begin
            errors++;
            $display("FAIL %s victim_way: expected %0d, actual %0d",
                     name_q[n], exp_victim_q[n], victim_way);
        end
    endtask

    // Starts right after a rising edge, takes three cycles
    task automatic run_line(input int n);
        bit seen;
        seen = 1'b0;
        case (op_q[n])
            "L": begin
                lookup_valid <= 1'b1;
                lookup_index <= index_q[n];
                lookup_tag   <= tag_q[n];
            end
            "R": refill_valid <= 1'b1;
            "A": begin
                maint_valid <= 1'b1;
                maint_op    <= icache_cmd_pkg::MAINT_INV_ALL;
            end
            "I": begin
                maint_valid <= 1'b1;
                maint_op    <= icache_cmd_pkg::MAINT_INV_INDEX;
                maint_index <= index_q[n];
                maint_way   <= way_q[n];
            end
            default: begin
                $display("Unknown operation in line %s", name_q[n]);
                errors++;
            end
        endcase
        @(posedge clk);
        lookup_valid <= 1'b0;
        refill_valid <= 1'b0;
        maint_valid  <= 1'b0;
        if (op_q[n] == "L") begin
            for (int i = 0; i < 3 && !seen; i++) begin
                @(negedge clk);
                seen = result_valid;
            end
            if (seen) begin
                check_result(n);
            end else begin
                errors++;
                $display("Lookup %s got no result_valid within 3 cycles", name_q[n]);
            end
            @(posedge clk);
        end else begin
            repeat (2) @(posedge clk);
        end
    endtask

    initial begin
        errors       = 0;
        checks       = 0;
        limit        = 0;
        reset        = 1'b1;
        lookup_valid = 1'b0;
        lookup_index = '0;
        lookup_tag   = '0;
        refill_valid = 1'b0;
        maint_valid  = 1'b0;
        maint_op     = icache_cmd_pkg::MAINT_INV_ALL;
        maint_index  = '0;
        maint_way    = 1'b0;
        read_input_file();
        limit = 3 * op_q.size() + timeout_margin;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        // LRU clear sweep
        repeat (16) @(posedge clk);
        for (int n = 0; n < op_q.size(); n++) begin
            run_line(n);
        end
        $display("Lines: %0d, checks: %0d, errors: %0d", op_q.size(), checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// File: testbench/icache_tag_asserts.sv
`timescale 1ns/100ps

module icache_tag_asserts (
    input logic                      clk,
    input logic                      reset,
    input logic                      lookup_valid,
    input logic                      refill_valid,
    input icache_cmd_pkg::tagv_cmd_e cmd,
    input logic                      lookup_done
);

    // Command register idles out of reset
    a_cmd_idle: assert property (@(posedge clk) reset |=> cmd == icache_cmd_pkg::CMD_NONE)
        else $error("Write command not idle in the cycle after reset");

    // Result strobe only two edges after a sampled lookup
    a_done_after_lookup: assert property (@(posedge clk) disable iff (reset)
        lookup_done |-> $past(lookup_valid, 2))
        else $error("lookup_done without a lookup two edges earlier");

    // Refill takes the buffered request, a new lookup would overwrite it
    a_no_fill_on_lookup: assert property (@(posedge clk) disable iff (reset)
        refill_valid |-> !lookup_valid)
        else $error("Refill sampled together with a lookup");

endmodule

bind icache_tag_ctrl icache_tag_asserts u_asserts (
    .clk          (clk),
    .reset        (reset),
    .lookup_valid (lookup_valid),
    .refill_valid (refill_valid),
    .cmd          (cmd_q),
    .lookup_done  (lookup_done)
);

// File: src/icache_tag.sv
`timescale 1ns/100ps

module icache_tag (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      lookup_valid,
    input  icache_geom_pkg::index_t   lookup_index,
    input  icache_geom_pkg::tag_t     lookup_tag,
    input  logic                      refill_valid,
    input  logic                      maint_valid,
    input  icache_cmd_pkg::maint_op_e maint_op,
    input  icache_geom_pkg::index_t   maint_index,
    input  logic                      maint_way,
    output logic                      result_valid,
    output icache_geom_pkg::way_vec_t hit,
    output logic                      hit_way,
    output logic                      victim_way
);

    tagv_wr_if wr ();

    icache_tag_ctrl u_ctrl (
        .clk          (clk),
        .reset        (reset),
        .lookup_valid (lookup_valid),
        .lookup_index (lookup_index),
        .lookup_tag   (lookup_tag),
        .refill_valid (refill_valid),
        .maint_valid  (maint_valid),
        .maint_op     (maint_op),
        .maint_index  (maint_index),
        .maint_way    (maint_way),
        .victim_way   (victim_way),
        .wr           (wr.ctrl),
        .lookup_done  (result_valid)
    );

    icache_tagv u_tagv (
        .clk   (clk),
        .reset (reset),
        .wr    (wr.array),
        .hit   (hit)
    );

    icache_lru u_lru (
        .clk         (clk),
        .reset       (reset),
        .wr          (wr.array),
        .hit         (hit),
        .lookup_done (result_valid),
        .victim_way  (victim_way)
    );

    // Encode the hitting way, zero on a miss
    always_comb begin
        hit_way = 1'b0;
        for (int w = 0; w < icache_geom_pkg::ways; w++) begin
            if (hit[w]) begin
                hit_way = 1'(w);
            end
        end
    end

endmodule

// File: src/icache_tag_ctrl.sv
`timescale 1ns/100ps

module icache_tag_ctrl (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        lookup_valid,
    input  icache_geom_pkg::index_t     lookup_index,
    input  icache_geom_pkg::tag_t       lookup_tag,
    input  logic                        refill_valid,
    input  logic                        maint_valid,
    input  icache_cmd_pkg::maint_op_e   maint_op,
    input  icache_geom_pkg::index_t     maint_index,
    input  logic                        maint_way,
    input  logic                        victim_way,
    tagv_wr_if.ctrl                     wr,
    output logic                        lookup_done
);

    ////////////////////////////////////////////////////////////////////////////
    // Request buffer
    ////////////////////////////////////////////////////////////////////////////

    icache_geom_pkg::index_t   req_index;
    icache_geom_pkg::tag_t     req_tag;
    logic                      lookup_q1;
    logic                      lookup_q2;

    icache_cmd_pkg::tagv_cmd_e cmd_q;
    icache_geom_pkg::index_t   wr_index_q;
    icache_geom_pkg::tag_t     wr_tag_q;
    logic                      wr_way_q;

    // Held until the next lookup
    always_ff @(posedge clk) begin
        if (lookup_valid) begin
            req_index <= lookup_index;
            req_tag   <= lookup_tag;
        end
    end

    // Result strobe two edges after the lookup
    always_ff @(posedge clk) begin
        if (reset) begin
            lookup_q1 <= 1'b0;
            lookup_q2 <= 1'b0;
        end else begin
            lookup_q1 <= lookup_valid;
            lookup_q2 <= lookup_q1;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Command register
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            cmd_q <= icache_cmd_pkg::CMD_NONE;
        end else if (refill_valid) begin
            cmd_q <= icache_cmd_pkg::CMD_FILL;
        end else if (maint_valid) begin
            cmd_q <= (maint_op == icache_cmd_pkg::MAINT_INV_ALL) ?
                     icache_cmd_pkg::CMD_INV_ALL : icache_cmd_pkg::CMD_INV_INDEX;
        end else begin
            cmd_q <= icache_cmd_pkg::CMD_NONE;
        end
    end

    // Refill goes to the victim of the buffered set
    always_ff @(posedge clk) begin
        if (refill_valid) begin
            wr_index_q <= req_index;
            wr_tag_q   <= req_tag;
            wr_way_q   <= victim_way;
        end else if (maint_valid) begin
            wr_index_q <= maint_index;
            wr_tag_q   <= '0;
            wr_way_q   <= maint_way;
        end
    end

    assign wr.cmd      = cmd_q;
    assign wr.wr_index = wr_index_q;
    assign wr.wr_tag   = wr_tag_q;
    assign wr.wr_way   = wr_way_q;
    assign wr.rd_index = req_index;
    assign wr.cmp_tag  = req_tag;

    assign lookup_done = lookup_q2;

endmodule

// File: src/icache_lru.sv
`timescale 1ns/100ps

module icache_lru (
    input  logic                      clk,
    input  logic                      reset,
    tagv_wr_if.array                  wr,
    input  icache_geom_pkg::way_vec_t hit,
    input  logic                      lookup_done,
    output logic                      victim_way
);

    logic                    sweep_active;
    icache_geom_pkg::index_t sweep_idx;
    logic                    lru_we;
    icache_geom_pkg::index_t lru_waddr;
    logic                    lru_din;

    // Clear sweep over all sets after reset
    always_ff @(posedge clk) begin
        if (reset) begin
            sweep_active <= 1'b1;
            sweep_idx    <= '0;
        end else if (sweep_active) begin
            sweep_idx <= sweep_idx + 1'b1;
            if (sweep_idx == icache_geom_pkg::index_t'(icache_geom_pkg::sets - 1)) begin
                sweep_active <= 1'b0;
            end
        end
    end

    // Stored bit names the next victim, i.e. the way not used last
    always_comb begin
        lru_we    = 1'b0;
        lru_waddr = wr.rd_index;
        lru_din   = 1'b0;
        if (sweep_active) begin
            lru_we    = 1'b1;
            lru_waddr = sweep_idx;
        end else if (wr.cmd == icache_cmd_pkg::CMD_FILL) begin
            lru_we    = 1'b1;
            lru_waddr = wr.wr_index;
            lru_din   = ~wr.wr_way;
        end else if (lookup_done && (|hit)) begin
            lru_we  = 1'b1;
            lru_din = ~hit[1];
        end
    end

    lutram #(
        .payload_t (logic)
    ) u_lru (
        .clk   (clk),
        .we    (lru_we),
        .waddr (lru_waddr),
        .din   (lru_din),
        .raddr (wr.rd_index),
        .dout  (victim_way)
    );

endmodule

// File: src/icache_tagv.sv
`timescale 1ns/100ps

module icache_tagv (
    input  logic                      clk,
    input  logic                      reset,
    tagv_wr_if.array                  wr,
    output icache_geom_pkg::way_vec_t hit
);

    ////////////////////////////////////////////////////////////////////////////
    // One tag memory and one valid vector per way
    ////////////////////////////////////////////////////////////////////////////

    for (genvar w = 0; w < icache_geom_pkg::ways; w++) begin : g_way
        logic [icache_geom_pkg::sets-1:0] valid;
        logic                             valid_q;
        logic                             sel;
        logic                             fill;
        logic                             inv_one;
        logic                             clear_all;
        logic                             tag_we;
        icache_geom_pkg::tag_t            tag_din;
        icache_geom_pkg::tag_t            tag_rd;

        assign sel       = (wr.wr_way == 1'(w));
        assign fill      = (wr.cmd == icache_cmd_pkg::CMD_FILL) && sel;
        assign inv_one   = (wr.cmd == icache_cmd_pkg::CMD_INV_INDEX) && sel;
        // Reset behaves like an invalidate-all
        assign clear_all = reset || (wr.cmd == icache_cmd_pkg::CMD_INV_ALL);

        // Index-invalidate zeroes the tag too
        assign tag_we  = fill || inv_one;
        assign tag_din = inv_one ? '0 : wr.wr_tag;

        lutram #(
            .payload_t (icache_geom_pkg::tag_t)
        ) u_tag (
            .clk   (clk),
            .we    (tag_we),
            .waddr (wr.wr_index),
            .din   (tag_din),
            .raddr (wr.rd_index),
            .dout  (tag_rd)
        );

        always_ff @(posedge clk) begin
            if (clear_all) begin
                valid <= '0;
            end else if (fill) begin
                valid[wr.wr_index] <= 1'b1;
            end else if (inv_one) begin
                valid[wr.wr_index] <= 1'b0;
            end
        end

        // Registered valid bit, write to the same set takes priority
        always_ff @(posedge clk) begin
            if (clear_all) begin
                valid_q <= 1'b0;
            end else if (tag_we && (wr.wr_index == wr.rd_index)) begin
                valid_q <= fill;
            end else begin
                valid_q <= valid[wr.rd_index];
            end
        end

        assign hit[w] = valid_q && (tag_rd == wr.cmp_tag);
    end

endmodule

// File: src/lutram.sv
`timescale 1ns/100ps

module lutram #(
    parameter type payload_t = icache_geom_pkg::tag_t
) (
    input  logic                    clk,
    input  logic                    we,
    input  icache_geom_pkg::index_t waddr,
    input  payload_t                din,
    input  icache_geom_pkg::index_t raddr,
    output payload_t                dout
);

    payload_t mem [icache_geom_pkg::sets];

    // Write on the edge
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= din;
        end
    end

    // Combinational read port
    assign dout = mem[raddr];

endmodule

// File: src/tagv_wr_if.sv
`timescale 1ns/100ps

interface tagv_wr_if;

    // Write side
    icache_cmd_pkg::tagv_cmd_e cmd;
    icache_geom_pkg::index_t   wr_index;
    icache_geom_pkg::tag_t     wr_tag;
    logic                      wr_way;

    // Lookup side, held from the request buffer
    icache_geom_pkg::index_t   rd_index;
    icache_geom_pkg::tag_t     cmp_tag;

    modport ctrl (
        output cmd, wr_index, wr_tag, wr_way, rd_index, cmp_tag
    );

    modport array (
        input cmd, wr_index, wr_tag, wr_way, rd_index, cmp_tag
    );

endinterface

// File: src/icache_cmd_pkg.sv
package icache_cmd_pkg;

    // Maintenance operations from the pipeline
    typedef enum logic {
        MAINT_INV_ALL   = 1'b0,
        MAINT_INV_INDEX = 1'b1
    } maint_op_e;

    // Array write command, valid for one cycle
    typedef enum logic [1:0] {
        CMD_NONE      = 2'b00,
        CMD_FILL      = 2'b01,
        CMD_INV_INDEX = 2'b10,
        CMD_INV_ALL   = 2'b11
    } tagv_cmd_e;

endpackage

// File: src/icache_geom_pkg.sv
package icache_geom_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Cache geometry
    ////////////////////////////////////////////////////////////////////////////

    // 16 sets, 2 ways
    localparam int index_bits = 4;
    localparam int tag_bits   = 25;
    localparam int ways       = 2;

    // Entries per way memory
    localparam int sets = 1 << index_bits;

    typedef logic [index_bits-1:0] index_t;
    typedef logic [tag_bits-1:0]   tag_t;

    // One bit per way
    typedef logic [ways-1:0] way_vec_t;

endpackage
